/* source/ppu_pkg.sv */
// ##############################
// PPU background shared definitions
// Register map, frame constants, bus, timing and scroll types
// ##############################
`default_nettype none

package ppu_pkg;

  // CPU register indices on the 3-bit bus address
  localparam logic [2:0] reg_ctrl   = 3'd0;
  localparam logic [2:0] reg_mask   = 3'd1;
  localparam logic [2:0] reg_status = 3'd2;
  localparam logic [2:0] reg_scroll = 3'd5;
  localparam logic [2:0] reg_addr   = 3'd6;
  localparam logic [2:0] reg_data   = 3'd7;

  // Frame geometry
  localparam logic [8:0] cycles_per_line     = 9'd341;
  localparam logic [8:0] last_cycle          = cycles_per_line - 9'd1;
  localparam logic [8:0] vblank_line         = 9'd240;  // Post-render line, vblank begins after it
  localparam logic [8:0] prerender_from_line = 9'd260;  // Last vblank line
  localparam logic [8:0] prerender_line      = 9'd511;  // Line -1

  localparam logic [5:0]  palette_page     = 6'h3f;    // Address bits 13..8 of palette space
  localparam logic [14:0] addr_incr_across = 15'd32;   // Step down one tile row

  typedef struct packed {
    logic [2:0] ain;    // Register select
    logic [7:0] din;
    logic       read;   // One-cycle strobe
    logic       write;  // One-cycle strobe
  } cpu_bus_t;

  typedef struct packed {
    logic [8:0] scanline;
    logic [8:0] cycle;
    logic       in_vblank;
    logic       end_of_line;      // Cycle 340
    logic       last_group;       // Cycles 336 and up
    logic       entering_vblank;  // End of line 240
    logic       exiting_vblank;   // End of line 260
    logic       pre_render;       // On line -1
  } timing_t;

  typedef struct packed {
    logic       bg_patt;     // Background pattern table select
    logic       addr_incr;   // Data port steps by 32
    logic       vbl_enable;  // NMI on vblank
    logic       grayscale;
    logic       bg_clip;     // Show background in left 8 pixels
    logic       bg_enable;
    logic [2:0] emphasis;
  } ctrl_t;

  typedef struct packed {
    logic [2:0] fine_y;
    logic       nt_y;
    logic       nt_x;
    logic [4:0] coarse_y;
    logic [4:0] coarse_x;
  } loopy_fields_t;

  // Scroll fields while rendering, flat VRAM address for CPU access
  typedef union packed {
    loopy_fields_t fields;
    logic [14:0]   flat;
  } loopy_addr_u;

endpackage

`default_nettype wire

/* source/ppu_timing.sv */
// ##############################
// PPU timing generator
// Pixel cycle and scanline counters with vblank flags
// ##############################
`default_nettype none

module ppu_timing (
  input  wire              clk,
  input  wire              reset,
  output ppu_pkg::timing_t timing
);
  import ppu_pkg::*;

  logic [8:0] scanline_q;       // 0..260 then 511 for line -1
  logic [8:0] cycle_q;          // Pixel clock within the line
  logic       in_vblank_q;
  logic       end_of_line;
  logic       last_group;
  logic       entering_vblank;
  logic       exiting_vblank;
  logic       pre_render;

  assign end_of_line     = (cycle_q == last_cycle);
  assign last_group      = (cycle_q[8:3] == 6'd42);  // Final partial group of eight
  assign entering_vblank = end_of_line && (scanline_q == vblank_line);
  assign exiting_vblank  = end_of_line && (scanline_q == prerender_from_line);
  assign pre_render      = (scanline_q == prerender_line);

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle_q     <= '0;
      scanline_q  <= '0;
      in_vblank_q <= 1'b1;
    end else begin
      cycle_q <= end_of_line ? 9'd0 : cycle_q + 9'd1;
      if (end_of_line) begin
        // 511 + 1 rolls over to line 0
        scanline_q <= exiting_vblank ? prerender_line : scanline_q + 9'd1;
      end
      if (entering_vblank)
        in_vblank_q <= 1'b1;
      else if (exiting_vblank)
        in_vblank_q <= 1'b0;
    end
  end

  assign timing = '{scanline: scanline_q, cycle: cycle_q, in_vblank: in_vblank_q,
                    end_of_line: end_of_line, last_group: last_group,
                    entering_vblank: entering_vblank, exiting_vblank: exiting_vblank,
                    pre_render: pre_render};

endmodule

`default_nettype wire

/* source/ppu_regs.sv */
// ##############################
// PPU CPU register block
// Control and mask, status with NMI, read buffer
// ##############################
`default_nettype none

module ppu_regs (
  input  wire                    clk,
  input  wire                    reset,
  input  wire ppu_pkg::cpu_bus_t cpu,
  input  wire ppu_pkg::timing_t  timing,
  input  wire                    pal_select,
  input  wire [5:0]              color,
  input  wire [7:0]              vram_din,
  output ppu_pkg::ctrl_t         ctrl,
  output logic                   is_rendering,
  output logic                   nmi,
  output logic [7:0]             dout
);
  import ppu_pkg::*;

  ctrl_t      ctrl_q;
  logic       nmi_occurred;   // Vblank seen and not yet acknowledged
  logic       status_rd;
  logic       data_rd;
  logic       data_rd_q;      // VRAM byte for the last data read is on vram_din now
  logic [7:0] read_buf;

  assign status_rd = cpu.read && (cpu.ain == reg_status);
  assign data_rd   = cpu.read && (cpu.ain == reg_data);

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_q <= '0;
    end else if (cpu.write) begin
      case (cpu.ain)
        reg_ctrl: begin
          ctrl_q.addr_incr  <= cpu.din[2];
          ctrl_q.bg_patt    <= cpu.din[4];
          ctrl_q.vbl_enable <= cpu.din[7];
        end
        reg_mask: begin
          ctrl_q.grayscale <= cpu.din[0];
          ctrl_q.bg_clip   <= cpu.din[1];
          ctrl_q.bg_enable <= cpu.din[3];
          ctrl_q.emphasis  <= cpu.din[7:5];
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      nmi_occurred <= 1'b0;
      data_rd_q    <= 1'b0;
      read_buf     <= '0;
      dout         <= '0;
    end else begin
      if (status_rd)
        nmi_occurred <= 1'b0;  // Acknowledge wins over a same-cycle set
      else if (timing.entering_vblank)
        nmi_occurred <= 1'b1;
      else if (timing.exiting_vblank)
        nmi_occurred <= 1'b0;
      data_rd_q <= data_rd;
      if (data_rd_q)
        read_buf <= vram_din;  // One cycle behind the strobe
      if (status_rd)
        dout <= {nmi_occurred, 2'b00, dout[4:0]};  // Sprite flags read as zero
      else if (data_rd)
        dout <= pal_select ? {dout[7:6], color} : read_buf;
      else if (cpu.write)
        dout <= cpu.din;  // Bus keeps the last written value
    end
  end

  assign ctrl         = ctrl_q;
  assign is_rendering = ctrl_q.bg_enable && !timing.in_vblank && (timing.scanline != vblank_line);
  assign nmi          = nmi_occurred && ctrl_q.vbl_enable;

endmodule

`default_nettype wire

/* source/loopy_scroll.sv */
// ##############################
// Scroll and VRAM address registers
// CPU writes plus rendering increments of v
// ##############################
`default_nettype none

module loopy_scroll (
  input  wire                    clk,
  input  wire                    reset,
  input  wire ppu_pkg::cpu_bus_t cpu,
  input  wire ppu_pkg::timing_t  timing,
  input  wire ppu_pkg::ctrl_t    ctrl,
  input  wire                    is_rendering,
  output ppu_pkg::loopy_addr_u   v,
  output logic [2:0]             fine_x
);
  import ppu_pkg::*;

  loopy_addr_u v_q;          // Current address
  loopy_addr_u t_q;          // Temporary address, loaded by the CPU
  logic [2:0]  fine_x_q;
  logic        toggle;       // Next scroll or address write is the second one
  logic        x_step;
  logic [14:0] data_step;

  // After each attribute fetch, on visible pixels and the two prefetch tiles
  assign x_step = (timing.cycle[2:0] == 3'd3) &&
                  ((timing.cycle < 9'd256) || ((timing.cycle >= 9'd320) && (timing.cycle < 9'd336)));
  assign data_step = ctrl.addr_incr ? addr_incr_across : 15'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      v_q.flat <= '0;
      t_q.flat <= '0;
      fine_x_q <= '0;
      toggle   <= 1'b0;
    end else begin
      if (is_rendering) begin
        if (x_step) begin
          v_q.fields.coarse_x <= v_q.fields.coarse_x + 5'd1;
          if (v_q.fields.coarse_x == 5'd31)
            v_q.fields.nt_x <= !v_q.fields.nt_x;  // Wrap into the next name table
        end
        if (timing.cycle == 9'd251) begin
          v_q.fields.fine_y <= v_q.fields.fine_y + 3'd1;
          if (v_q.fields.fine_y == 3'd7) begin
            if (v_q.fields.coarse_y == 5'd29) begin  // Row 29 is the last tile row
              v_q.fields.coarse_y <= '0;
              v_q.fields.nt_y     <= !v_q.fields.nt_y;
            end else begin
              v_q.fields.coarse_y <= v_q.fields.coarse_y + 5'd1;
            end
          end
        end
        if (timing.cycle == 9'd256) begin
          v_q.fields.nt_x     <= t_q.fields.nt_x;  // Horizontal bits back from t
          v_q.fields.coarse_x <= t_q.fields.coarse_x;
        end
        if ((timing.cycle == 9'd304) && timing.pre_render)
          v_q <= t_q;
      end
      if (cpu.write && (cpu.ain == reg_ctrl)) begin
        t_q.fields.nt_x <= cpu.din[0];
        t_q.fields.nt_y <= cpu.din[1];
      end else if (cpu.write && (cpu.ain == reg_scroll)) begin
        if (!toggle) begin
          t_q.fields.coarse_x <= cpu.din[7:3];
          fine_x_q            <= cpu.din[2:0];
        end else begin
          t_q.fields.coarse_y <= cpu.din[7:3];
          t_q.fields.fine_y   <= cpu.din[2:0];
        end
        toggle <= !toggle;
      end else if (cpu.write && (cpu.ain == reg_addr)) begin
        if (!toggle) begin
          t_q.flat[14:8] <= {1'b0, cpu.din[5:0]};  // High byte, bit 14 cleared
        end else begin
          t_q.flat[7:0] <= cpu.din;
          v_q.flat      <= {t_q.flat[14:8], cpu.din};
        end
        toggle <= !toggle;
      end else if (cpu.read && (cpu.ain == reg_status)) begin
        toggle <= 1'b0;
      end else if ((cpu.read || cpu.write) && (cpu.ain == reg_data) && !is_rendering) begin
        v_q.flat <= v_q.flat + data_step;
      end
    end
  end

  assign v      = v_q;
  assign fine_x = fine_x_q;

endmodule

`default_nettype wire

/* source/bg_painter.sv */
// ##############################
// Background tile fetch and shifter
// Captures tile bytes and shifts out pixels
// ##############################
`default_nettype none

module bg_painter (
  input  wire                       clk,
  input  wire                       reset,
  input  wire ppu_pkg::timing_t     timing,
  input  wire ppu_pkg::ctrl_t       ctrl,
  input  wire ppu_pkg::loopy_addr_u v,
  input  wire [2:0]                 fine_x,
  input  wire [7:0]                 vram_din,
  output logic [7:0]                name_table,
  output logic [3:0]                pixel
);

  logic [7:0]  name_q;          // Tile index for the pattern fetch
  logic [1:0]  attr_q;          // Palette select of this tile
  logic [7:0]  patt_lo_q;       // Low bit plane
  logic [15:0] pipe_lo;
  logic [15:0] pipe_hi;
  logic [8:0]  pipe_al;         // Attribute bit 0, one per tile
  logic [8:0]  pipe_ah;
  logic [1:0]  quadrant;
  logic        show_low;

  // Leftmost pixel is the pattern MSB
  function automatic logic [7:0] reverse8(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++)
      r[i] = b[7 - i];
    return r;
  endfunction

  assign quadrant = {v.fields.coarse_y[1], v.fields.coarse_x[1]};

  always_ff @(posedge clk) begin
    case (timing.cycle[2:0])
      3'd1: name_q <= vram_din;
      3'd3: attr_q <= vram_din[{quadrant, 1'b0} +: 2];
      3'd5: patt_lo_q <= vram_din;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pipe_lo <= '0;
      pipe_hi <= '0;
      pipe_al <= '0;
      pipe_ah <= '0;
    end else if (!timing.last_group) begin
      pipe_lo[14:0] <= pipe_lo[15:1];
      pipe_hi[14:0] <= pipe_hi[15:1];
      pipe_al[7:0]  <= pipe_al[8:1];
      pipe_ah[7:0]  <= pipe_ah[8:1];
      if (timing.cycle[2:0] == 3'd7) begin  // High plane arrives now
        pipe_lo[15:8] <= reverse8(patt_lo_q);
        pipe_hi[15:8] <= reverse8(vram_din);
        pipe_al[8]    <= attr_q[0];
        pipe_ah[8]    <= attr_q[1];
      end
    end
  end

  assign show_low   = ctrl.bg_enable && (ctrl.bg_clip || (timing.cycle[7:3] != 5'd0));
  assign name_table = name_q;
  assign pixel = {pipe_ah[fine_x], pipe_al[fine_x],
                  show_low ? {pipe_hi[fine_x], pipe_lo[fine_x]} : 2'b00};

endmodule

`default_nettype wire

/* source/palette_ram.sv */
// ##############################
// Palette colour memory
// 32 entries with backdrop mirroring
// ##############################
`default_nettype none

module palette_ram (
  input  wire        clk,
  input  wire [4:0]  addr,
  input  wire [5:0]  din,
  input  wire        write,
  input  wire        grayscale,
  output logic [5:0] color
);

  logic [5:0] mem [32];
  logic [4:0] index;
  logic [5:0] raw;

  // Entries 10, 14, 18 and 1C alias the background backdrops
  assign index = (addr[1:0] == 2'b00) ? {1'b0, addr[3:0]} : addr;
  assign raw   = mem[index];  // Asynchronous read

  always_ff @(posedge clk) begin
    if (write)
      mem[index] <= din;
  end

  assign color = grayscale ? {raw[5:4], 4'b0000} : raw;  // Keep luma only

endmodule

`default_nettype wire

/* source/ppu_top.sv */
// ##############################
// PPU background top level
// Wires the blocks, forms VRAM address and strobes
// ##############################
`default_nettype none

module ppu_top (
  input  wire                    clk,
  input  wire                    reset,
  input  wire ppu_pkg::cpu_bus_t cpu,
  output logic [7:0]             dout,
  output logic                   nmi,
  output logic [13:0]            vram_a,
  output logic                   vram_r,
  output logic                   vram_w,
  input  wire [7:0]              vram_din,
  output logic [7:0]             vram_dout,
  output logic [8:0]             scanline,
  output logic [8:0]             cycle,
  output logic [5:0]             color,
  output logic [2:0]             emphasis
);
  import ppu_pkg::*;

  timing_t     timing;
  ctrl_t       ctrl;
  logic        is_rendering;
  loopy_addr_u v;
  logic [2:0]  fine_x;
  logic [7:0]  name_table;
  logic [3:0]  pixel;
  logic        pal_select;  // v points into palette space
  logic        data_rd;
  logic        data_wr;
  logic [4:0]  pal_addr;
  logic        pal_write;

  ppu_timing timing_gen (.clk, .reset, .timing);
  ppu_regs regs (.clk, .reset, .cpu, .timing, .pal_select, .color, .vram_din,
                 .ctrl, .is_rendering, .nmi, .dout);
  loopy_scroll scroll (.clk, .reset, .cpu, .timing, .ctrl, .is_rendering, .v, .fine_x);
  bg_painter painter (.clk, .reset, .timing, .ctrl, .v, .fine_x, .vram_din, .name_table, .pixel);
  palette_ram palette (.clk, .addr(pal_addr), .din(cpu.din[5:0]), .write(pal_write),
                       .grayscale(ctrl.grayscale), .color);

  assign pal_select = (v.flat[13:8] == palette_page);
  assign data_rd    = cpu.read && (cpu.ain == reg_data);
  assign data_wr    = cpu.write && (cpu.ain == reg_data);

  always_comb begin
    if (!is_rendering) begin
      vram_a = v.flat[13:0];  // CPU access
    end else begin
      case (timing.cycle[2:1])
        2'd0: vram_a = {2'b10, v.flat[11:0]};  // Name table byte
        2'd1: vram_a = {2'b10, v.flat[11:10], 4'b1111, v.flat[9:7], v.flat[4:2]};
        default: vram_a = {1'b0, ctrl.bg_patt, name_table, timing.cycle[1], v.fields.fine_y};
      endcase
    end
  end

  assign vram_r    = data_rd || (is_rendering && !timing.cycle[0] && !timing.end_of_line);
  assign vram_w    = data_wr && !pal_select && !is_rendering;
  assign vram_dout = cpu.din;
  assign pal_addr  = is_rendering ? ((pixel[1:0] != 2'b00) ? {1'b0, pixel} : 5'd0)
                                  : (pal_select ? v.flat[4:0] : 5'd0);  // Backdrop otherwise
  assign pal_write = data_wr && pal_select;
  assign scanline  = timing.scanline;
  assign cycle     = timing.cycle;
  assign emphasis  = ctrl.emphasis;

endmodule

`default_nettype wire

/* bench/ppu_assert.sv */
// ##############################
// PPU background assertions
// VRAM strobe and NMI rules on the top level
// ##############################
`default_nettype none

module ppu_assert (
  input wire       clk,
  input wire       reset,
  input wire       vram_r,
  input wire       vram_w,
  input wire       bg_enable,
  input wire [8:0] scanline,
  input wire       nmi,
  input wire       in_vblank
);
  timeunit 1ns;
  timeprecision 100ps;
  import ppu_pkg::*;

  int   violations = 0;  // Failures so far
  logic rendering;       // Fetch window from the frame position

  assign rendering = bg_enable && !in_vblank && (scanline != vblank_line);

  rw_exclusive: assert property (@(posedge clk) disable iff (reset) !(vram_r && vram_w))
    else begin
      $error("vram_r and vram_w high together");
      violations++;
    end

  // CPU writes to VRAM only outside rendering
  no_write_rendering: assert property (@(posedge clk) disable iff (reset)
                                       !(vram_w && rendering))
    else begin
      $error("vram_w high while rendering");
      violations++;
    end

  nmi_in_vblank: assert property (@(posedge clk) disable iff (reset) nmi |-> in_vblank)
    else begin
      $error("nmi high outside vblank");
      violations++;
    end

endmodule

bind ppu_top ppu_assert checks (.clk, .reset, .vram_r, .vram_w,
                                .bg_enable(ctrl.bg_enable), .scanline, .nmi,
                                .in_vblank(timing.in_vblank));

`default_nettype wire

/* bench/ppu_tb.sv */
// ##############################
// PPU background testbench
// Random CPU traffic against VRAM, timing and palette models
// ##############################
`default_nettype none

module ppu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import ppu_pkg::*;

  logic        clk;
  logic        reset;
  cpu_bus_t    cpu;
  logic [7:0]  dout;
  logic        nmi;
  logic [13:0] vram_a;
  logic        vram_r;
  logic        vram_w;
  logic [7:0]  vram_din = '0;
  logic [7:0]  vram_dout;
  logic [8:0]  scanline;
  logic [8:0]  cycle;
  logic [5:0]  color;
  logic [2:0]  emphasis;

  integer      seed = 52211;
  logic [13:0] addr_q = '0;       // VRAM address at the last rising edge
  logic        patt_zero = 1'b0;  // Pattern tables read as zero
  logic [8:0]  m_line;            // Frame position model
  logic [8:0]  m_cycle;
  logic        track = 1'b0;      // Model valid, reset is over
  logic [5:0]  pal_model [32];
  logic        seen_r;            // Strobes and bus sampled inside a CPU access
  logic        seen_w;
  logic [13:0] seen_a;
  logic [7:0]  seen_dout;
  logic [7:0]  rd_data;           // dout one clock after the strobe

  ppu_top UUT (.clk, .reset, .cpu, .dout, .nmi, .vram_a, .vram_r, .vram_w, .vram_din,
               .vram_dout, .scanline, .cycle, .color, .emphasis);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // VRAM contents follow the address
  function automatic logic [7:0] vram_data(input logic [13:0] a);
    if (patt_zero && !a[13])
      return 8'h00;
    return a[7:0] ^ {2'b00, a[13:8]};
  endfunction

  // Backdrop entries of the sprite half alias the background half
  function automatic logic [4:0] mirror_index(input logic [4:0] i);
    return (i[1:0] == 2'b00) ? (i & 5'h0f) : i;
  endfunction

  always @(posedge clk) addr_q <= vram_a;
  always @(negedge clk) vram_din <= vram_data(addr_q);  // One cycle read latency

  always @(posedge clk) begin
    track <= !reset;
    if (reset) begin
      m_line  <= 9'd0;
      m_cycle <= 9'd0;
    end else if (m_cycle == 9'd340) begin
      m_cycle <= 9'd0;
      if (m_line == 9'd260)
        m_line <= 9'd511;  // Pre-render line
      else if (m_line == 9'd511)
        m_line <= 9'd0;
      else
        m_line <= m_line + 9'd1;
    end else begin
      m_cycle <= m_cycle + 9'd1;
    end
  end

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s = %0h, expected %0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  always @(negedge clk) begin
    if (track) begin
      check_value("scanline", scanline, m_line);
      check_value("cycle", cycle, m_cycle);
    end
  end

  // One strobe cycle, then one idle cycle
  task automatic cpu_access(input logic rd, input logic [2:0] ain, input logic [7:0] din);
    @(negedge clk);
    cpu.ain   = ain;
    cpu.din   = din;
    cpu.read  = rd;
    cpu.write = !rd;
    #2;
    seen_r    = vram_r;
    seen_w    = vram_w;
    seen_a    = vram_a;
    seen_dout = vram_dout;
    @(negedge clk);
    cpu.read  = 1'b0;
    cpu.write = 1'b0;
    rd_data   = dout;
    @(negedge clk);
  endtask

  task automatic point_v(input logic [13:0] a);
    cpu_access(1'b0, reg_addr, {2'b00, a[13:8]});
    cpu_access(1'b0, reg_addr, a[7:0]);
  endtask

  task automatic wait_for(input logic [8:0] line, input logic [8:0] cyc);
    int n;
    n = 0;
    while (!((scanline == line) && (cycle == cyc))) begin
      @(negedge clk);
      n++;
      if (n > 2 * 262 * 341) begin
        $display("Timed out waiting for line %0d cycle %0d", line, cyc);
        abort_run();
      end
    end
  endtask

  initial begin
    logic [31:0] rnd;
    logic [14:0] a;
    logic [7:0]  exp_buf;
    logic [7:0]  prev;
    logic [5:0]  exp_color;
    logic [4:0]  idx;
    reset = 1'b1;
    cpu   = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    check_value("nmi", nmi, 0);
    check_value("vram_w", vram_w, 0);
    check_value("dout", dout, 0);

    // Data-port writes with random steps
    rnd = $random(seed);
    a = {1'b0, rnd[13] & ~rnd[12], rnd[12:0]};  // Below 3000h, away from palette
    point_v(a[13:0]);
    repeat (8) begin
      rnd = $random(seed);
      cpu_access(1'b0, reg_ctrl, {5'b10000, rnd[8], 2'b00});  // NMI on, step select
      cpu_access(1'b0, reg_data, rnd[7:0]);
      check_value("vram_w", seen_w, 1);
      check_value("vram_r", seen_r, 0);
      check_value("vram_a", seen_a, a[13:0]);
      check_value("vram_dout", seen_dout, rnd[7:0]);
      check_value("dout", rd_data, rnd[7:0]);
      a = a + (rnd[8] ? 15'd32 : 15'd1);
    end

    // Data-port reads return the byte of the previous read
    rnd = $random(seed);
    a = {1'b0, rnd[13] & ~rnd[12], rnd[12:0]};
    point_v(a[13:0]);
    exp_buf = 8'h00;  // Nothing read since reset
    repeat (8) begin
      rnd = $random(seed);
      cpu_access(1'b0, reg_ctrl, {5'b10000, rnd[0], 2'b00});
      cpu_access(1'b1, reg_data, 8'h00);
      check_value("vram_r", seen_r, 1);
      check_value("vram_w", seen_w, 0);
      check_value("vram_a", seen_a, a[13:0]);
      check_value("dout", rd_data, exp_buf);
      exp_buf = vram_data(a[13:0]);
      a = a + (rnd[0] ? 15'd32 : 15'd1);
    end

    // Fill the palette, then look entries up through v
    cpu_access(1'b0, reg_ctrl, 8'h80);
    point_v(14'h3f00);
    idx = 5'd0;
    repeat (32) begin
      rnd = $random(seed);
      cpu_access(1'b0, reg_data, {2'b00, rnd[5:0]});
      check_value("vram_w", seen_w, 0);
      pal_model[mirror_index(idx)] = rnd[5:0];
      idx = idx + 5'd1;
    end
    repeat (12) begin
      rnd = $random(seed);
      idx = rnd[4:0];
      // Random emphasis and grayscale, background stays off
      cpu_access(1'b0, reg_mask, {rnd[8:6], 4'b0000, rnd[5]});
      check_value("emphasis", emphasis, rnd[8:6]);
      point_v({6'h3f, 3'b000, idx});
      exp_color = pal_model[mirror_index(idx)];
      if (rnd[5])
        exp_color = exp_color & 6'h30;
      check_value("color", color, exp_color);
    end

    // NMI rises after line 240, status read acknowledges it
    wait_for(9'd240, 9'd340);
    check_value("nmi", nmi, 0);
    @(negedge clk);
    check_value("nmi", nmi, 1);
    prev = rd_data;
    cpu_access(1'b1, reg_status, 8'h00);
    check_value("dout", rd_data, {3'b100, prev[4:0]});
    check_value("nmi", nmi, 0);

    // Background on with blank patterns, backdrop everywhere
    patt_zero = 1'b1;
    cpu_access(1'b0, reg_mask, 8'h0a);
    wait_for(9'd0, 9'd0);
    repeat (240 * 341) begin
      if (cycle < 9'd256)
        check_value("color", color, pal_model[0]);
      @(negedge clk);
    end

    // Unacknowledged NMI drops when vblank ends
    wait_for(9'd240, 9'd340);
    check_value("nmi", nmi, 0);
    @(negedge clk);
    check_value("nmi", nmi, 1);
    wait_for(9'd260, 9'd340);
    check_value("nmi", nmi, 1);
    @(negedge clk);
    check_value("nmi", nmi, 0);
    wait_for(9'd0, 9'd0);  // Through line -1 back to 0

    if (UUT.checks.violations == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Assertions failed %0d times", UUT.checks.violations);
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* ppu_top.f */
source/ppu_pkg.sv
source/ppu_timing.sv
source/ppu_regs.sv
source/loopy_scroll.sv
source/bg_painter.sv
source/palette_ram.sv
source/ppu_top.sv
bench/ppu_assert.sv
bench/ppu_tb.sv

/* Bender.yml */
package:
  name: ppu_top

sources:
  - source/ppu_pkg.sv
  - source/ppu_timing.sv
  - source/ppu_regs.sv
  - source/loopy_scroll.sv
  - source/bg_painter.sv
  - source/palette_ram.sv
  - source/ppu_top.sv
  - target: test
    files:
      - bench/ppu_assert.sv
      - bench/ppu_tb.sv
